//--- common/slink_pkg.sv
// Serial-link request multiplexer shared definitions
// Widths, payload structs and APB register offsets

package slink_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned num_ports  = 4;
  localparam int unsigned port_idx_w = $clog2(num_ports);
  localparam int unsigned addr_w     = 32;
  localparam int unsigned data_w     = 32;
  localparam int unsigned up_id_w    = 4;
  localparam int unsigned dn_id_w    = up_id_w + port_idx_w; // Port index on top

  typedef logic [port_idx_w-1:0] port_idx_t;
  typedef logic [num_ports-1:0]  port_mask_t;
  typedef logic [15:0]           grant_cnt_t; // Wraps at 2^16

  ////////////////////////////////////////////////////////////
  // Payloads
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic               write;
    logic [addr_w-1:0]  addr;
    logic [data_w-1:0]  wdata;
    logic [up_id_w-1:0] id;
  } up_req_t;

  typedef struct packed {
    logic               write;
    logic [addr_w-1:0]  addr;
    logic [data_w-1:0]  wdata;
    logic [dn_id_w-1:0] id;
  } dn_req_t;

  typedef struct packed {
    logic [data_w-1:0]  rdata;
    logic               err;
    logic [up_id_w-1:0] id;
  } up_rsp_t;

  typedef struct packed {
    logic [data_w-1:0]  rdata;
    logic               err;
    logic [dn_id_w-1:0] id;
  } dn_rsp_t;

  // Register map, counter p sits at reg_cnt_base_off + 4*p
  localparam logic [addr_w-1:0] reg_ctrl_off     = 32'h0000_0000;
  localparam logic [addr_w-1:0] reg_cnt_base_off = 32'h0000_0004;

endpackage

//--- common/mux_cfg_if.sv
// Configuration and grant reporting between register block and port mux

`timescale 1ns/1ps

interface mux_cfg_if;
  import slink_pkg::*;

  port_mask_t port_en;     // Per-port enable
  logic       fixed_prio;  // 1 = fixed priority, 0 = round-robin
  logic       grant_stb;   // One pulse per accepted request
  port_idx_t  grant_port;

  modport regs (
    output port_en, fixed_prio,
    input  grant_stb, grant_port
  );

  modport mux (
    input  port_en, fixed_prio,
    output grant_stb, grant_port
  );

endinterface

//--- logic/spill_reg.sv
// Single-entry valid/ready register stage
// One cycle latency, accepts a new item while the held one leaves

`timescale 1ns/1ps

module spill_reg #(
  parameter type payload_t = logic
) (
  input  logic     periph_clk,
  input  logic     rst_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     full_q;
  payload_t data_q;
  logic     load;

  // Room when empty or when the held item drains this cycle
  assign in_ready_o = ~full_q | out_ready_i;
  assign load       = in_valid_i & in_ready_o;

  always_ff @(posedge periph_clk) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (in_ready_o) begin
      full_q <= in_valid_i;
    end
  end

  always_ff @(posedge periph_clk) begin
    if (load) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = full_q;
  assign out_data_o  = data_q;

endmodule

//--- logic/slink_mux_regs.sv
// APB register block for the request multiplexer
// Holds port enable mask and arbitration mode, counts grants per port

`timescale 1ns/1ps

module slink_mux_regs (
  input  logic                      periph_clk,
  input  logic                      rst_i,
  input  logic [slink_pkg::addr_w-1:0] paddr_i,
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [slink_pkg::data_w-1:0] pwdata_i,
  output logic [slink_pkg::data_w-1:0] prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  mux_cfg_if.regs                   cfg
);
  import slink_pkg::*;

  port_mask_t port_en_q;
  logic       fixed_prio_q;
  grant_cnt_t cnt_q [num_ports];

  logic       access;
  logic       wr_access;
  logic       hit_ctrl;
  port_mask_t hit_cnt;
  logic       addr_ok;

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  assign access    = psel_i & penable_i;
  assign wr_access = access & pwrite_i;
  assign hit_ctrl  = (paddr_i == reg_ctrl_off);

  for (genvar p = 0; p < num_ports; p++) begin : gen_cnt_dec
    assign hit_cnt[p] = (paddr_i == reg_cnt_base_off + addr_w'(4 * p));
  end

  assign addr_ok   = hit_ctrl | (|hit_cnt);
  assign pready_o  = 1'b1;             // Zero wait states
  assign pslverr_o = access & ~addr_ok;

  // Read mux, unused bits read as zero
  always_comb begin
    prdata_o = '0;
    if (hit_ctrl) begin
      prdata_o[3:0] = port_en_q;
      prdata_o[8]   = fixed_prio_q;
    end
    for (int p = 0; p < num_ports; p++) begin
      if (hit_cnt[p]) begin
        prdata_o = data_w'(cnt_q[p]);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge periph_clk) begin
    if (rst_i) begin
      port_en_q    <= '1;
      fixed_prio_q <= 1'b0;
    end else if (wr_access && hit_ctrl) begin
      port_en_q    <= pwdata_i[3:0];
      fixed_prio_q <= pwdata_i[8];
    end
  end

  for (genvar p = 0; p < num_ports; p++) begin : gen_cnt
    always_ff @(posedge periph_clk) begin
      if (rst_i) begin
        cnt_q[p] <= '0;
      end else if (wr_access && hit_cnt[p]) begin
        cnt_q[p] <= '0;                  // Any write clears
      end else if (cfg.grant_stb && cfg.grant_port == port_idx_t'(p)) begin
        cnt_q[p] <= cnt_q[p] + grant_cnt_t'(1);
      end
    end
  end

  assign cfg.port_en    = port_en_q;
  assign cfg.fixed_prio = fixed_prio_q;

endmodule

//--- mux/rr_arbiter.sv
// Port arbiter, round-robin or fixed priority
// Grant is combinational, pointer moves past the winner on advance

`timescale 1ns/1ps

module rr_arbiter (
  input  logic                  periph_clk,
  input  logic                  rst_i,
  input  slink_pkg::port_mask_t req_i,
  input  logic                  fixed_prio_i,
  input  logic                  advance_i,
  output logic                  grant_valid_o,
  output slink_pkg::port_idx_t  grant_idx_o
);
  import slink_pkg::*;

  port_idx_t ptr_q;
  port_idx_t start_idx;

  assign start_idx = fixed_prio_i ? '0 : ptr_q;

  ////////////////////////////////////////////////////////////
  // Search
  ////////////////////////////////////////////////////////////

  // Walk backwards so the port closest to start_idx wins
  always_comb begin
    grant_valid_o = 1'b0;
    grant_idx_o   = '0;
    for (int i = num_ports - 1; i >= 0; i--) begin
      if (req_i[start_idx + port_idx_t'(i)]) begin
        grant_valid_o = 1'b1;
        grant_idx_o   = start_idx + port_idx_t'(i); // Wraps modulo num_ports
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Pointer
  ////////////////////////////////////////////////////////////

  // Only moves on an accepted grant
  always_ff @(posedge periph_clk) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (advance_i && grant_valid_o) begin
      ptr_q <= grant_idx_o + port_idx_t'(1);
    end
  end

endmodule

//--- mux/port_mux.sv
// Upstream request multiplexer
// Arbitrates enabled ports, puts the port index above the ID, registers the winner

`timescale 1ns/1ps

module port_mux (
  input  logic                                             periph_clk,
  input  logic                                             rst_i,
  input  slink_pkg::port_mask_t                            up_req_valid_i,
  output slink_pkg::port_mask_t                            up_req_ready_o,
  input  slink_pkg::up_req_t [slink_pkg::num_ports-1:0]    up_req_i,
  output logic                                             dn_req_valid_o,
  input  logic                                             dn_req_ready_i,
  output slink_pkg::dn_req_t                               dn_req_o,
  mux_cfg_if.mux                                           cfg
);
  import slink_pkg::*;

  port_mask_t req_masked;
  logic       grant_valid;
  port_idx_t  grant_idx;
  logic       push_ready;
  logic       push;
  dn_req_t    push_data;

  assign req_masked = up_req_valid_i & cfg.port_en; // Disabled ports never compete
  assign push       = grant_valid & push_ready;

  rr_arbiter u_arb (
    .periph_clk    ( periph_clk     ),
    .rst_i         ( rst_i          ),
    .req_i         ( req_masked     ),
    .fixed_prio_i  ( cfg.fixed_prio ),
    .advance_i     ( push           ),
    .grant_valid_o ( grant_valid    ),
    .grant_idx_o   ( grant_idx      )
  );

  // Widen ID with the issuing port
  always_comb begin
    push_data.write = up_req_i[grant_idx].write;
    push_data.addr  = up_req_i[grant_idx].addr;
    push_data.wdata = up_req_i[grant_idx].wdata;
    push_data.id    = {grant_idx, up_req_i[grant_idx].id};
  end

  always_comb begin
    up_req_ready_o            = '0;
    up_req_ready_o[grant_idx] = push;
  end

  spill_reg #(
    .payload_t ( dn_req_t )
  ) u_req_spill (
    .periph_clk  ( periph_clk     ),
    .rst_i       ( rst_i          ),
    .in_valid_i  ( grant_valid    ),
    .in_ready_o  ( push_ready     ),
    .in_data_i   ( push_data      ),
    .out_valid_o ( dn_req_valid_o ),
    .out_ready_i ( dn_req_ready_i ),
    .out_data_o  ( dn_req_o       )
  );

  assign cfg.grant_stb  = push;
  assign cfg.grant_port = grant_idx;

endmodule

//--- mux/rsp_demux.sv
// Response router, registers link responses and steers each to its port
// Port index comes from the top ID bits, which are stripped on the way out

`timescale 1ns/1ps

module rsp_demux (
  input  logic                                          periph_clk,
  input  logic                                          rst_i,
  input  logic                                          dn_rsp_valid_i,
  output logic                                          dn_rsp_ready_o,
  input  slink_pkg::dn_rsp_t                            dn_rsp_i,
  output slink_pkg::port_mask_t                         up_rsp_valid_o,
  input  slink_pkg::port_mask_t                         up_rsp_ready_i,
  output slink_pkg::up_rsp_t [slink_pkg::num_ports-1:0] up_rsp_o
);
  import slink_pkg::*;

  logic      rsp_valid;
  logic      rsp_ready;
  dn_rsp_t   rsp_q;
  port_idx_t rsp_port;

  spill_reg #(
    .payload_t ( dn_rsp_t )
  ) u_rsp_spill (
    .periph_clk  ( periph_clk     ),
    .rst_i       ( rst_i          ),
    .in_valid_i  ( dn_rsp_valid_i ),
    .in_ready_o  ( dn_rsp_ready_o ),
    .in_data_i   ( dn_rsp_i       ),
    .out_valid_o ( rsp_valid      ),
    .out_ready_i ( rsp_ready      ),
    .out_data_o  ( rsp_q          )
  );

  assign rsp_port  = rsp_q.id[dn_id_w-1 -: port_idx_w];
  assign rsp_ready = up_rsp_ready_i[rsp_port]; // Only the addressed port counts

  always_comb begin
    up_rsp_valid_o           = '0;
    up_rsp_valid_o[rsp_port] = rsp_valid;
    for (int p = 0; p < num_ports; p++) begin
      up_rsp_o[p].rdata = rsp_q.rdata;
      up_rsp_o[p].err   = rsp_q.err;
      up_rsp_o[p].id    = rsp_q.id[up_id_w-1:0];
    end
  end

endmodule

//--- mux/slink_mux_top.sv
// Serial-link request multiplexer top level
// APB register block, four-port request mux and response router

`timescale 1ns/1ps

module slink_mux_top (
  input  logic                                          periph_clk,
  input  logic                                          rst_i,
  // APB slave
  input  logic [slink_pkg::addr_w-1:0]                  paddr_i,
  input  logic                                          psel_i,
  input  logic                                          penable_i,
  input  logic                                          pwrite_i,
  input  logic [slink_pkg::data_w-1:0]                  pwdata_i,
  output logic [slink_pkg::data_w-1:0]                  prdata_o,
  output logic                                          pready_o,
  output logic                                          pslverr_o,
  // Upstream ports
  input  slink_pkg::port_mask_t                         up_req_valid_i,
  output slink_pkg::port_mask_t                         up_req_ready_o,
  input  slink_pkg::up_req_t [slink_pkg::num_ports-1:0] up_req_i,
  output slink_pkg::port_mask_t                         up_rsp_valid_o,
  input  slink_pkg::port_mask_t                         up_rsp_ready_i,
  output slink_pkg::up_rsp_t [slink_pkg::num_ports-1:0] up_rsp_o,
  // Link side
  output logic                                          dn_req_valid_o,
  input  logic                                          dn_req_ready_i,
  output slink_pkg::dn_req_t                            dn_req_o,
  input  logic                                          dn_rsp_valid_i,
  output logic                                          dn_rsp_ready_o,
  input  slink_pkg::dn_rsp_t                            dn_rsp_i
);

  mux_cfg_if u_cfg ();

  slink_mux_regs u_regs (
    .periph_clk ( periph_clk ),
    .rst_i      ( rst_i      ),
    .paddr_i    ( paddr_i    ),
    .psel_i     ( psel_i     ),
    .penable_i  ( penable_i  ),
    .pwrite_i   ( pwrite_i   ),
    .pwdata_i   ( pwdata_i   ),
    .prdata_o   ( prdata_o   ),
    .pready_o   ( pready_o   ),
    .pslverr_o  ( pslverr_o  ),
    .cfg        ( u_cfg.regs )
  );

  // Request path
  port_mux u_port_mux (
    .periph_clk     ( periph_clk     ),
    .rst_i          ( rst_i          ),
    .up_req_valid_i ( up_req_valid_i ),
    .up_req_ready_o ( up_req_ready_o ),
    .up_req_i       ( up_req_i       ),
    .dn_req_valid_o ( dn_req_valid_o ),
    .dn_req_ready_i ( dn_req_ready_i ),
    .dn_req_o       ( dn_req_o       ),
    .cfg            ( u_cfg.mux      )
  );

  // Response path
  rsp_demux u_rsp_demux (
    .periph_clk     ( periph_clk     ),
    .rst_i          ( rst_i          ),
    .dn_rsp_valid_i ( dn_rsp_valid_i ),
    .dn_rsp_ready_o ( dn_rsp_ready_o ),
    .dn_rsp_i       ( dn_rsp_i       ),
    .up_rsp_valid_o ( up_rsp_valid_o ),
    .up_rsp_ready_i ( up_rsp_ready_i ),
    .up_rsp_o       ( up_rsp_o       )
  );

endmodule

//--- bench/tb_clk_gen.sv
// Testbench clock and reset source
// 100 ns clock period, reset held high for two cycles

`timescale 1ns/1ps

module tb_clk_gen (
  output logic periph_clk,
  output logic rst_i
);

  initial begin
    periph_clk = 1'b0;
    forever #50 periph_clk = ~periph_clk;
  end

  initial begin
    rst_i = 1'b1;
    repeat (2) @(posedge periph_clk);
    #10 rst_i = 1'b0;
  end

endmodule

//--- bench/slink_mux_assertions.sv
// Protocol assertions for the request multiplexer
// Handshake stability, one-hot response valid, no grant on disabled ports

`timescale 1ns/1ps

module slink_mux_assertions (
  input logic                                          periph_clk,
  input logic                                          rst_i,
  input logic                                          dn_req_valid_o,
  input logic                                          dn_req_ready_i,
  input slink_pkg::dn_req_t                            dn_req_o,
  input slink_pkg::port_mask_t                         up_req_valid_i,
  input slink_pkg::port_mask_t                         up_req_ready_o,
  input slink_pkg::port_mask_t                         up_rsp_valid_o,
  input slink_pkg::port_mask_t                         up_rsp_ready_i,
  input slink_pkg::up_rsp_t [slink_pkg::num_ports-1:0] up_rsp_o,
  input slink_pkg::port_mask_t                         port_en_i
);

  int unsigned fail_cnt = 0;

  a_dn_req_hold: assert property (@(posedge periph_clk) disable iff (rst_i)
    dn_req_valid_o && !dn_req_ready_i |=> dn_req_valid_o && $stable(dn_req_o))
    else begin
      $error("downstream request dropped or changed before acceptance");
      fail_cnt++;
    end

  a_up_rsp_hold: assert property (@(posedge periph_clk) disable iff (rst_i)
    (up_rsp_valid_o & ~up_rsp_ready_i) != '0 |=> $stable(up_rsp_valid_o) && $stable(up_rsp_o))
    else begin
      $error("upstream response dropped or changed before acceptance");
      fail_cnt++;
    end

  a_up_rsp_onehot: assert property (@(posedge periph_clk) disable iff (rst_i)
    $onehot0(up_rsp_valid_o))
    else begin
      $error("more than one upstream response valid");
      fail_cnt++;
    end

  a_no_disabled_grant: assert property (@(posedge periph_clk) disable iff (rst_i)
    (up_req_valid_i & up_req_ready_o & ~port_en_i) == '0)
    else begin
      $error("request accepted on a disabled port");
      fail_cnt++;
    end

endmodule

bind slink_mux_top slink_mux_assertions u_asrt (
  .periph_clk     ( periph_clk      ),
  .rst_i          ( rst_i           ),
  .dn_req_valid_o ( dn_req_valid_o  ),
  .dn_req_ready_i ( dn_req_ready_i  ),
  .dn_req_o       ( dn_req_o        ),
  .up_req_valid_i ( up_req_valid_i  ),
  .up_req_ready_o ( up_req_ready_o  ),
  .up_rsp_valid_o ( up_rsp_valid_o  ),
  .up_rsp_ready_i ( up_rsp_ready_i  ),
  .up_rsp_o       ( up_rsp_o        ),
  .port_en_i      ( u_cfg.port_en   )
);

//--- bench/tb_slink_mux.sv
// Testbench for the serial-link request multiplexer
// Upstream stimulus, downstream link model, scoreboard and APB checks

`timescale 1ns/1ps

module tb_slink_mux;
  import slink_pkg::*;

  localparam int max_cycles = 4000; // About twice the longest run

  logic                          periph_clk;
  logic                          rst_i;
  logic [addr_w-1:0]             paddr_i;
  logic                          psel_i;
  logic                          penable_i;
  logic                          pwrite_i;
  logic [data_w-1:0]             pwdata_i;
  logic [data_w-1:0]             prdata_o;
  logic                          pready_o;
  logic                          pslverr_o;
  port_mask_t                    up_req_valid_i;
  port_mask_t                    up_req_ready_o;
  up_req_t [num_ports-1:0]       up_req_i;
  port_mask_t                    up_rsp_valid_o;
  port_mask_t                    up_rsp_ready_i;
  up_rsp_t [num_ports-1:0]       up_rsp_o;
  logic                          dn_req_valid_o;
  logic                          dn_req_ready_i;
  dn_req_t                       dn_req_o;
  logic                          dn_rsp_valid_i;
  logic                          dn_rsp_ready_o;
  dn_rsp_t                       dn_rsp_i;

  up_req_t    stim_q [num_ports][$];   // Requests still to issue
  up_rsp_t    up_exp_q [num_ports][$]; // Expected responses per port
  dn_req_t    exp_dn_q [$];
  dn_rsp_t    pending_q [$];           // Link model, in order
  grant_cnt_t seen_cnt [num_ports];
  port_mask_t cur_en;
  port_mask_t up_fire;
  logic       rsp_fire;
  logic       bp_en;
  logic       rr_chk;
  logic       rr_have;
  port_idx_t  rr_last;
  logic       fx_chk;
  logic [31:0] lfsr_state;
  int         rsp_delay;
  int         errors;
  int         checks;
  int         issued;
  int         done;
  int         cycles;

  tb_clk_gen u_clk (
    .periph_clk ( periph_clk ),
    .rst_i      ( rst_i      )
  );

  slink_mux_top dut0 (.*);

  ////////////////////////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32,22,2,1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Read data the link returns for an address
  function automatic logic [data_w-1:0] model_rdata(input logic [addr_w-1:0] addr,
                                                    input logic write);
    if (write) begin
      return ~addr;
    end
    return {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
  endfunction

  function automatic port_idx_t first_set(input port_mask_t m);
    port_idx_t r;
    r = '0;
    for (int i = num_ports - 1; i >= 0; i--) begin
      if (m[i]) r = port_idx_t'(i);
    end
    return r;
  endfunction

  function automatic int outstanding();
    int n;
    n = exp_dn_q.size() + pending_q.size();
    for (int p = 0; p < num_ports; p++) begin
      n = n + stim_q[p].size() + up_exp_q[p].size();
    end
    return n;
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_dn_req(input dn_req_t got, input dn_req_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: downstream request %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_up_rsp(input up_rsp_t got, input up_rsp_t exp, input int p);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: response on port %0d is %h, expected %h", $time, p, got, exp);
    end
  endtask

  task automatic check_reg(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
                           input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_port(input port_idx_t got, input port_idx_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: %s gave port %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  ////////////////////////////////////////////////////////////
  // Drivers, 10 ns after the rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge periph_clk) begin
    logic [31:0] tmp;
    #10;
    for (int p = 0; p < num_ports; p++) begin
      if (up_fire[p]) void'(stim_q[p].pop_front());
      up_req_valid_i[p] = (stim_q[p].size() > 0);
      if (stim_q[p].size() > 0) up_req_i[p] = stim_q[p][0];
    end
    if (rsp_fire) begin
      void'(pending_q.pop_front());
      tmp = rand_bits(2);
      rsp_delay = int'(tmp[1:0]);
    end else if (rsp_delay > 0) begin
      rsp_delay--;
    end
    dn_rsp_valid_i = (pending_q.size() > 0) && (rsp_delay == 0);
    if (pending_q.size() > 0) dn_rsp_i = pending_q[0];
    if (bp_en) begin
      tmp = rand_bits(1);
      dn_req_ready_i = tmp[0];
      tmp = rand_bits(num_ports);
      up_rsp_ready_i = tmp[num_ports-1:0];
    end else begin
      dn_req_ready_i = 1'b1;
      up_rsp_ready_i = '1;
    end
  end

  always @(posedge periph_clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("Timeout: run did not finish within %0d cycles", max_cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Monitor and compare, sampled at the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge periph_clk) begin
    dn_req_t   exp;
    dn_rsp_t   rsp;
    up_rsp_t   ue;
    port_idx_t port;
    if (!rst_i) begin
      up_fire  = up_req_valid_i & up_req_ready_o;
      rsp_fire = dn_rsp_valid_i & dn_rsp_ready_o;
      if (dn_req_valid_o && dn_req_ready_i) begin
        port = dn_req_o.id[dn_id_w-1 -: port_idx_w];
        if (exp_dn_q.size() == 0) begin
          note_failure("downstream request without a matching upstream request");
        end else begin
          exp = exp_dn_q.pop_front();
          check_dn_req(dn_req_o, exp);
          port     = exp.id[dn_id_w-1 -: port_idx_w]; // Issuing port
          ue.rdata = model_rdata(exp.addr, exp.write);
          ue.err   = 1'b0;
          ue.id    = exp.id[up_id_w-1:0];
          up_exp_q[port].push_back(ue);
        end
        seen_cnt[port] = seen_cnt[port] + grant_cnt_t'(1);
        rsp.rdata = model_rdata(dn_req_o.addr, dn_req_o.write);
        rsp.err   = 1'b0;
        rsp.id    = dn_req_o.id;
        pending_q.push_back(rsp);
        if (rr_chk) begin
          if (rr_have) check_port(port, rr_last + port_idx_t'(1), "round-robin");
          rr_have = 1'b1;
          rr_last = port;
        end
      end
      for (int p = 0; p < num_ports; p++) begin
        if (up_fire[p]) begin
          if (!cur_en[p]) note_failure("request accepted on a disabled port");
          if (fx_chk) check_port(port_idx_t'(p), first_set(up_req_valid_i & cur_en), "priority");
          exp.write = up_req_i[p].write;
          exp.addr  = up_req_i[p].addr;
          exp.wdata = up_req_i[p].wdata;
          exp.id    = {port_idx_t'(p), up_req_i[p].id};
          exp_dn_q.push_back(exp);
          issued++;
        end
        if (up_rsp_valid_o[p] && up_rsp_ready_i[p]) begin
          if (up_exp_q[p].size() == 0) begin
            note_failure("response returned on a port with nothing outstanding");
          end else begin
            check_up_rsp(up_rsp_o[p], up_exp_q[p].pop_front(), p);
          end
          done++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic apb_access(input logic wr, input logic [addr_w-1:0] addr,
                            input logic [data_w-1:0] wdata,
                            output logic [data_w-1:0] rdata, output logic err);
    @(posedge periph_clk);
    #10;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(posedge periph_clk);
    #10;
    penable_i = 1'b1;
    @(negedge periph_clk);
    rdata = prdata_o;
    err   = pslverr_o;
    if (pready_o !== 1'b1) note_failure("APB access phase ended without pready");
    @(posedge periph_clk);
    #10;
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic queue_random(input int p, input int n);
    up_req_t     r;
    logic [31:0] tmp;
    for (int i = 0; i < n; i++) begin
      tmp = rand_bits(1);
      r.write = tmp[0];
      r.addr  = rand_bits(32);
      r.wdata = rand_bits(32);
      tmp = rand_bits(up_id_w);
      r.id    = tmp[up_id_w-1:0];
      stim_q[p].push_back(r);
    end
  endtask

  task automatic wait_drain();
    while (outstanding() != 0) @(posedge periph_clk);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [data_w-1:0] rd;
    logic              err;
    {paddr_i, psel_i, penable_i, pwrite_i, pwdata_i} = '0;
    up_req_valid_i = '0;
    up_req_i       = '0;
    up_rsp_ready_i = '1;
    dn_req_ready_i = 1'b1;
    dn_rsp_valid_i = 1'b0;
    dn_rsp_i       = '0;
    lfsr_state = 32'h668f361b;
    {up_fire, rsp_fire, bp_en, rr_chk, rr_have, fx_chk} = '0;
    rr_last = '0;
    cur_en  = '1;
    {rsp_delay, errors, checks, issued, done, cycles} = '0;
    for (int p = 0; p < num_ports; p++) seen_cnt[p] = '0;
    while (rst_i) @(posedge periph_clk);

    // CTRL readback
    apb_access(1'b1, reg_ctrl_off, 32'hffff_ff0a, rd, err);
    apb_access(1'b0, reg_ctrl_off, '0, rd, err);
    check_reg(rd, 32'h0000_010a, "CTRL");
    check_reg({31'd0, err}, 32'd0, "pslverr at CTRL");
    apb_access(1'b1, reg_ctrl_off, 32'h0000_000f, rd, err);

    // Round-robin with every port busy
    rr_chk = 1'b1;
    for (int p = 0; p < num_ports; p++) queue_random(p, 4);
    wait_drain();
    rr_chk = 1'b0;

    // Fixed priority, port 2 masked off
    apb_access(1'b1, reg_ctrl_off, 32'h0000_010b, rd, err);
    cur_en = 4'b1011;
    fx_chk = 1'b1;
    queue_random(0, 3);
    queue_random(1, 3);
    queue_random(2, 2);
    queue_random(3, 3);
    while (stim_q[0].size() + stim_q[1].size() + stim_q[3].size() != 0) begin
      @(posedge periph_clk);
    end
    if (stim_q[2].size() != 2) note_failure("disabled port 2 lost a queued request");
    apb_access(1'b1, reg_ctrl_off, 32'h0000_010f, rd, err);
    cur_en = '1;
    wait_drain();
    fx_chk = 1'b0;
    apb_access(1'b1, reg_ctrl_off, 32'h0000_000f, rd, err);

    // Grant counters and clear on write
    for (int p = 0; p < num_ports; p++) begin
      apb_access(1'b0, reg_cnt_base_off + 32'(4 * p), '0, rd, err);
      check_reg(rd, {16'h0, seen_cnt[p]}, "grant counter");
      apb_access(1'b1, reg_cnt_base_off + 32'(4 * p), 32'hdead_beef, rd, err);
      apb_access(1'b0, reg_cnt_base_off + 32'(4 * p), '0, rd, err);
      check_reg(rd, '0, "cleared grant counter");
      seen_cnt[p] = '0;
    end

    // Unmapped address
    apb_access(1'b0, 32'h0000_0020, '0, rd, err);
    check_reg({31'd0, err}, 32'd1, "pslverr at 0x20");

    // Random back-pressure on both paths
    @(negedge periph_clk);
    bp_en = 1'b1;
    for (int p = 0; p < num_ports; p++) queue_random(p, 25);
    wait_drain();
    bp_en = 1'b0;

    errors = errors + int'(dut0.u_asrt.fail_cnt);
    if (issued != done) note_failure("request and response counts differ");
    $display("Checks: %0d, errors: %0d, requests: %0d, responses: %0d",
             checks, errors, issued, done);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
common/slink_pkg.sv
common/mux_cfg_if.sv
logic/spill_reg.sv
logic/slink_mux_regs.sv
mux/rr_arbiter.sv
mux/port_mux.sv
mux/rsp_demux.sv
mux/slink_mux_top.sv
bench/tb_clk_gen.sv
bench/slink_mux_assertions.sv
bench/tb_slink_mux.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := tb_slink_mux
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
